// ==== Bender.yml ====
package:
  name: rect_overlay

sources:
  - include_dirs:
      - hw
    files:
      - hw/videoPkg.sv
      - hw/pixelPkg.sv
      - hw/rasterIf.sv
      - hw/rasterScan.sv
      - hw/rectDraw.sv
      - hw/layerMix.sv
      - hw/rectOverlay.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - dv/clkGen.sv
      - dv/rectOverlay_checker.sv
      - dv/rectOverlayTb.sv

// ==== dv/clkGen.sv ====
//--------------------------------------------------------------------------
// Testbench clock and reset
// Free running clock and a synchronous reset held for a few cycles
//--------------------------------------------------------------------------
`timescale 1ns/1ns

module clkGen #(
    parameter int pPeriod    = 40,      // ns
    parameter int pRstCycles = 5
)(
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(pPeriod / 2) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (pRstCycles) @(posedge clk);
        rst <= 1'b0;                        // Released on a rising edge
    end

endmodule

// ==== dv/rectOverlayTb.sv ====
//--------------------------------------------------------------------------
// Overlay engine testbench
// Directed tests over whole frames, each pixel checked against a model of
// the inclusive bounds and layer priority rules
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "overlay_consts.svh"

module rectOverlayTb;

    import pixelPkg::*;
    import videoPkg::*;

    localparam int pipeLat     = 3;                         // Scanner to output
    localparam int frameCycles = `OVL_H_TOTAL * `OVL_V_TOTAL;

    logic    iCLK, iRST;
    xPos_t   fillXs, fillXe, markXs, markXe;
    yPos_t   fillYs, fillYe, markYs, markYe;
    rgb_t    fillColor, bgColor, palData, oPixel;
    palIdx_t markIdx, palAddr;
    logic    palWe, oDe, oHsync, oVsync;

    rgb_t        palModel [`OVL_PAL_DEPTH];                 // Mirror of palette writes
    logic [31:0] lfsr;
    int          mismatchCount = 0;
    int          timeoutCount  = 0;

    clkGen #(.pPeriod(40), .pRstCycles(5)) clkGen_i (.clk(iCLK), .rst(iRST));

    rectOverlay rectOverlay_i (
        .iCLK(iCLK), .iRST(iRST),
        .iFillXs(fillXs), .iFillXe(fillXe), .iFillYs(fillYs), .iFillYe(fillYe),
        .iFillColor(fillColor),
        .iMarkXs(markXs), .iMarkXe(markXe), .iMarkYs(markYs), .iMarkYe(markYe),
        .iMarkIdx(markIdx), .iBgColor(bgColor),
        .iPalWe(palWe), .iPalAddr(palAddr), .iPalData(palData),
        .oPixel(oPixel), .oDe(oDe), .oHsync(oHsync), .oVsync(oVsync)
    );

    //----------------------------------------------------------------------
    // Random source, x^32 + x^22 + x^2 + x + 1
    //----------------------------------------------------------------------
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            val  = {val[30:0], fb};                         // One step per bit
        end
        return val;
    endfunction

    //----------------------------------------------------------------------
    // Reference model
    //----------------------------------------------------------------------
    function automatic bit inRect(input int x, input int y, input int xs,
                                  input int xe, input int ys, input int ye);
        return (x >= xs) && (x <= xe) && (y >= ys) && (y <= ye);   // Inclusive
    endfunction

    function automatic rgb_t expPixel(input int x, input int y);
        if ((x >= `OVL_H_ACTIVE) || (y >= `OVL_V_ACTIVE))
            return '0;                                      // Blanking
        if (inRect(x, y, markXs, markXe, markYs, markYe))
            return palModel[markIdx];
        if (inRect(x, y, fillXs, fillXe, fillYs, fillYe))
            return fillColor;
        return bgColor;
    endfunction

    //----------------------------------------------------------------------
    // Compare tasks
    //----------------------------------------------------------------------
    task automatic checkRgb(input string name, input rgb_t got, input rgb_t expected);
        if (got !== expected)
        begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, expected);
            mismatchCount++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, expected);
            mismatchCount++;
        end
    endtask

    task automatic checkCount(input string name, input int got, input int expected);
        if (got != expected)
        begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, expected);
            mismatchCount++;
        end
    endtask

    //----------------------------------------------------------------------
    // Stimulus and waits
    //----------------------------------------------------------------------
    // Returns negedges waited for the sync to reach level, -1 on timeout
    task automatic waitSyncEdge(input bit vert, input logic level, output int cycles);
        logic prev;
        logic cur;
        bit   seen;
        prev   = vert ? oVsync : oHsync;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < 2 * frameCycles)
        begin
            @(negedge iCLK);
            cycles++;
            cur  = vert ? oVsync : oHsync;
            seen = (prev !== level) && (cur === level);
            prev = cur;
        end
        if (!seen)
        begin
            $display("Timeout at %0t: %s never went %s", $time,
                     vert ? "oVsync" : "oHsync", level ? "high" : "low");
            timeoutCount++;
            cycles = -1;
        end
    endtask

    task automatic setFill(input xPos_t xs, input xPos_t xe, input yPos_t ys,
                           input yPos_t ye, input rgb_t color);
        @(posedge iCLK);
        fillXs    <= xs;
        fillXe    <= xe;
        fillYs    <= ys;
        fillYe    <= ye;
        fillColor <= color;
    endtask

    task automatic setMark(input xPos_t xs, input xPos_t xe, input yPos_t ys,
                           input yPos_t ye, input palIdx_t idx);
        @(posedge iCLK);
        markXs  <= xs;
        markXe  <= xe;
        markYs  <= ys;
        markYe  <= ye;
        markIdx <= idx;
    endtask

    task automatic writePalette(input palIdx_t addr, input rgb_t color);
        @(posedge iCLK);
        palWe          <= 1'b1;
        palAddr        <= addr;
        palData        <= color;
        palModel[addr]  = color;
        @(posedge iCLK);
        palWe          <= 1'b0;                             // Single write
    endtask

    // One whole frame, starting on the line after frame sync
    task automatic compareFrame();
        int x;
        int y;
        int n;
        waitSyncEdge(1'b1, 1'b0, n);
        x = 0;
        y = `OVL_VSYNC_START + `OVL_VSYNC_LEN;
        if (n >= 0)
        begin
            repeat (frameCycles)
            begin
                checkRgb($sformatf("oPixel(%0d,%0d)", x, y), oPixel, expPixel(x, y));
                checkBit("oDe", oDe, (x < `OVL_H_ACTIVE) && (y < `OVL_V_ACTIVE));
                checkBit("oHsync", oHsync, (x >= `OVL_HSYNC_START)
                         && (x < `OVL_HSYNC_START + `OVL_HSYNC_LEN));
                checkBit("oVsync", oVsync, (y >= `OVL_VSYNC_START)
                         && (y < `OVL_VSYNC_START + `OVL_VSYNC_LEN));
                @(negedge iCLK);
                x++;
                if (x == `OVL_H_TOTAL)
                begin
                    x = 0;
                    y = (y + 1) % `OVL_V_TOTAL;             // Frame wrap
                end
            end
        end
    endtask

    //----------------------------------------------------------------------
    // Directed tests
    //----------------------------------------------------------------------
    task automatic testStartup();
        int n;
        n = 0;
        @(negedge iCLK);
        while (iRST !== 1'b0 && n < 20)
        begin
            @(negedge iCLK);
            n++;
        end
        if (iRST !== 1'b0)
        begin
            $display("Timeout at %0t: reset was never released", $time);
            timeoutCount++;
        end
        // Outputs quiet until the first position comes through
        for (n = 0; n <= pipeLat; n++)
        begin
            checkBit("oDe", oDe, n == pipeLat);
            checkBit("oHsync", oHsync, 1'b0);
            checkBit("oVsync", oVsync, 1'b0);
            @(negedge iCLK);
        end
        waitSyncEdge(1'b0, 1'b1, n);
        waitSyncEdge(1'b0, 1'b1, n);
        checkCount("line period", n, `OVL_H_TOTAL);
        waitSyncEdge(1'b1, 1'b1, n);
        waitSyncEdge(1'b1, 1'b1, n);
        checkCount("frame period", n, frameCycles);
    endtask

    task automatic testEmpty();
        setFill(7'd40, 7'd10, 6'd30, 6'd5, 24'hff0000);    // Start past end
        setMark(7'd50, 7'd20, 6'd40, 6'd2, 4'd0);
        @(posedge iCLK);
        bgColor <= 24'h3a5c7e;
        compareFrame();
    endtask

    task automatic testFill();
        xPos_t xs, xe;
        yPos_t ys, ye;
        rgb_t  color;
        repeat (3)
        begin
            xs    = xPos_t'(randBits(6));
            xe    = xs + xPos_t'(randBits(4));
            ys    = yPos_t'(randBits(5));
            ye    = ys + yPos_t'(randBits(4));
            color = rgb_t'(randBits(24));
            setFill(xs, xe, ys, ye, color);
            compareFrame();
        end
        setFill(7'd63, 7'd63, 6'd47, 6'd47, 24'h00ff00);   // Last active pixel
        compareFrame();
        setFill(7'd0, 7'd0, 6'd0, 6'd47, 24'h0000ff);      // Left edge column
        compareFrame();
    endtask

    task automatic testMarker();
        writePalette(4'd3, 24'h20c0e0);
        writePalette(4'd9, rgb_t'(randBits(24)));
        setFill(7'd8, 7'd40, 6'd8, 6'd30, 24'hc08020);
        setMark(7'd20, 7'd50, 6'd20, 6'd40, 4'd9);         // Overlaps fill corner
        compareFrame();
        setMark(7'd20, 7'd50, 6'd20, 6'd40, 4'd3);
        compareFrame();
    endtask

    //----------------------------------------------------------------------
    // Main sequence
    //----------------------------------------------------------------------
    initial
    begin
        lfsr      = 32'h3704_361a;
        fillXs    = 7'd1;                                   // Empty rectangles
        fillXe    = 7'd0;
        fillYs    = 6'd1;
        fillYe    = 6'd0;
        fillColor = '0;
        markXs    = 7'd1;
        markXe    = 7'd0;
        markYs    = 6'd1;
        markYe    = 6'd0;
        markIdx   = '0;
        bgColor   = '0;
        palWe     = 1'b0;
        palAddr   = '0;
        palData   = '0;

        testStartup();
        testEmpty();
        testFill();
        testMarker();

        @(negedge iCLK);
        $display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
                 mismatchCount, timeoutCount, rectOverlay_i.rectOverlay_checker_i.assertFails);
        if (mismatchCount == 0 && timeoutCount == 0
            && rectOverlay_i.rectOverlay_checker_i.assertFails == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// ==== dv/rectOverlay_checker.sv ====
//--------------------------------------------------------------------------
// Overlay output checker
// Concurrent assertions on the pixel and sync outputs of the overlay top,
// bound into every instance of it
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "overlay_consts.svh"

module rectOverlay_checker
(
    input logic           iCLK,
    input logic           iRST,
    input pixelPkg::rgb_t pixel,
    input logic           de,
    input logic           hsync,
    input logic           vsync
);

    import pixelPkg::*;

    localparam rgb_t blackPixel = '0;

    int assertFails = 0;                    // Summed into the final count

    // No colour leaks into blanking
    blankIsBlack: assert property (@(posedge iCLK) disable iff (iRST)
        !de |-> (pixel == blackPixel))
    else
    begin
        $error("Pixel not black while data enable is low");
        assertFails++;
    end

    // Fixed line sync width
    hsyncWidth: assert property (@(posedge iCLK) disable iff (iRST)
        $rose(hsync) |-> hsync[*`OVL_HSYNC_LEN] ##1 !hsync)
    else
    begin
        $error("Line sync pulse has the wrong width");
        assertFails++;
    end

    // Active video never starts inside frame sync
    deOutsideVsync: assert property (@(posedge iCLK) disable iff (iRST)
        $rose(de) |-> !vsync)
    else
    begin
        $error("Data enable rose while frame sync was high");
        assertFails++;
    end

endmodule

bind rectOverlay rectOverlay_checker rectOverlay_checker_i (
    .iCLK(iCLK), .iRST(iRST), .pixel(oPixel),
    .de(oDe), .hsync(oHsync), .vsync(oVsync)
);

// ==== files.f ====
+incdir+hw
hw/videoPkg.sv
hw/pixelPkg.sv
hw/rasterIf.sv
hw/rasterScan.sv
hw/rectDraw.sv
hw/layerMix.sv
hw/rectOverlay.sv
dv/clkGen.sv
dv/rectOverlay_checker.sv
dv/rectOverlayTb.sv

// ==== hw/layerMix.sv ====
//--------------------------------------------------------------------------
// Layer mixer
// Marker over fill over background, with the marker colour looked up in
// a 16-entry palette. Syncs are realigned to the drawers and registered
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "overlay_consts.svh"

module layerMix
(
    input  logic              iCLK,
    input  logic              iRST,         // Sync, active high
    rasterIf.snk              ras,
    input  logic              iFillHit,
    input  pixelPkg::rgb_t    iFillColor,
    input  logic              iMarkHit,
    input  pixelPkg::palIdx_t iMarkIdx,
    input  pixelPkg::rgb_t    iBgColor,
    input  logic              iPalWe,       // Palette write strobe
    input  pixelPkg::palIdx_t iPalAddr,
    input  pixelPkg::rgb_t    iPalData,
    output pixelPkg::rgb_t    oPixel,
    output logic              oDe,
    output logic              oHsync,
    output logic              oVsync
);

    import pixelPkg::*;
    import videoPkg::*;

    rgb_t      palMem [`OVL_PAL_DEPTH];     // Marker palette
    rgb_t      palColor;
    rgb_t      qPixel;
    syncBits_t rSync  [0:1];                // Matches drawer latency

    //----------------------------------------------------------------------
    // Palette RAM
    //----------------------------------------------------------------------
    always_ff @(posedge iCLK)
    begin
        if (iPalWe)
            palMem[iPalAddr] <= iPalData;
    end

    assign palColor = palMem[iMarkIdx];     // Async read

    //----------------------------------------------------------------------
    // Timing alignment
    //----------------------------------------------------------------------
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            rSync[0] <= '0;
            rSync[1] <= '0;
        end
        else
        begin
            rSync[0] <= '{de: ras.de, hsync: ras.hsync, vsync: ras.vsync};
            rSync[1] <= rSync[0];
        end
    end

    //----------------------------------------------------------------------
    // Priority select
    //----------------------------------------------------------------------
    always_comb
    begin
        if (!rSync[1].de)
            qPixel = RGB_BLACK;             // Blanking
        else if (iMarkHit)
            qPixel = palColor;
        else if (iFillHit)
            qPixel = iFillColor;
        else
            qPixel = iBgColor;
    end

    // Output stage, one cycle after the hits
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            oPixel <= RGB_BLACK;
            oDe    <= 1'b0;
            oHsync <= 1'b0;
            oVsync <= 1'b0;
        end
        else
        begin
            oPixel <= qPixel;
            oDe    <= rSync[1].de;
            oHsync <= rSync[1].hsync;
            oVsync <= rSync[1].vsync;
        end
    end

endmodule

// ==== hw/overlay_consts.svh ====
//--------------------------------------------------------------------------
// Overlay engine constants
// Frame geometry, sync placement and palette depth for the shrunken
// 64x48 raster
//--------------------------------------------------------------------------
`ifndef OVERLAY_CONSTS_SVH
`define OVERLAY_CONSTS_SVH

// Horizontal geometry in pixels
`define OVL_H_ACTIVE      64
`define OVL_H_BLANK       16
`define OVL_HSYNC_LEN     8
`define OVL_H_TOTAL       (`OVL_H_ACTIVE + `OVL_H_BLANK)
`define OVL_HSYNC_START   (`OVL_H_ACTIVE + 4)     // 4 pixel front porch

// Vertical geometry in lines
`define OVL_V_ACTIVE      48
`define OVL_V_BLANK       4
`define OVL_VSYNC_LEN     2
`define OVL_V_TOTAL       (`OVL_V_ACTIVE + `OVL_V_BLANK)
`define OVL_VSYNC_START   (`OVL_V_ACTIVE + 1)     // 1 line front porch

// Coordinate widths, wide enough for the full totals
`define OVL_X_BITS        7
`define OVL_Y_BITS        6

`define OVL_PAL_DEPTH     16                      // Marker palette entries

`endif

// ==== hw/pixelPkg.sv ====
//--------------------------------------------------------------------------
// Pixel package
// Colour channel, true-colour pixel and palette index types shared by the
// drawers and the layer mixer
//--------------------------------------------------------------------------
`include "overlay_consts.svh"

package pixelPkg;

    // One 8-bit colour channel
    typedef logic [7:0] channel_t;

    // True-colour pixel, red in the top byte
    typedef struct packed
    {
        channel_t r;
        channel_t g;
        channel_t b;
    } rgb_t;

    // Index into the marker palette
    typedef logic [$clog2(`OVL_PAL_DEPTH)-1:0] palIdx_t;

    // Blanking colour
    localparam rgb_t RGB_BLACK = '{
        r: 8'h00,
        g: 8'h00,
        b: 8'h00
    };

endpackage

// ==== hw/rasterIf.sv ====
//--------------------------------------------------------------------------
// Raster position bundle
// Carries scan position, data enable and both syncs from the scanner to
// the drawers and the mixer
//--------------------------------------------------------------------------
`timescale 1ns/1ns

interface rasterIf;

    import videoPkg::*;

    xPos_t x;               // Pixel within the line
    yPos_t y;               // Line within the frame
    logic  de;              // High inside the active area
    logic  hsync;           // Active high
    logic  vsync;           // Active high

    // Scanner side
    modport src
    (
        output x, y, de, hsync, vsync
    );

    // Drawer and mixer side
    modport snk
    (
        input x, y, de, hsync, vsync
    );

endinterface

// ==== hw/rasterScan.sv ====
//--------------------------------------------------------------------------
// Raster scanner
// Walks every position of the frame, one per cycle, and drives the
// registered position, data enable and sync pulses
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "overlay_consts.svh"

module rasterScan
(
    input  logic  iCLK,
    input  logic  iRST,         // Sync, active high
    rasterIf.src  ras
);

    import videoPkg::*;

    xPos_t hCnt, hNext;         // Horizontal counter
    yPos_t vCnt, vNext;         // Vertical counter
    logic  rDe, rHs, rVs;

    //----------------------------------------------------------------------
    // Next position
    //----------------------------------------------------------------------
    always_comb
    begin
        hNext = hCnt + 1'b1;
        vNext = vCnt;
        if (hCnt == xPos_t'(`OVL_H_TOTAL - 1))
        begin
            hNext = '0;                             // Wrap line
            if (vCnt == yPos_t'(`OVL_V_TOTAL - 1))
                vNext = '0;                         // Wrap frame
            else
                vNext = vCnt + 1'b1;
        end
    end

    //----------------------------------------------------------------------
    // Registered outputs
    //----------------------------------------------------------------------
    // Flags are computed from the next position so they line up with it
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            hCnt <= '0;
            vCnt <= '0;
            rDe  <= 1'b1;                           // 0,0 is active
            rHs  <= 1'b0;
            rVs  <= 1'b0;
        end
        else
        begin
            hCnt <= hNext;
            vCnt <= vNext;
            rDe  <= (hNext < `OVL_H_ACTIVE) && (vNext < `OVL_V_ACTIVE);
            rHs  <= (hNext >= `OVL_HSYNC_START)
                 && (hNext <  `OVL_HSYNC_START + `OVL_HSYNC_LEN);
            rVs  <= (vNext >= `OVL_VSYNC_START)
                 && (vNext <  `OVL_VSYNC_START + `OVL_VSYNC_LEN);   // Whole lines
        end
    end

    assign ras.x     = hCnt;
    assign ras.y     = vCnt;
    assign ras.de    = rDe;
    assign ras.hsync = rHs;
    assign ras.vsync = rVs;

endmodule

// ==== hw/rectDraw.sv ====
//--------------------------------------------------------------------------
// Rectangle drawer
// Two-stage hit test of the raster position against inclusive bounds,
// with the payload delayed to match. Latency 2
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "overlay_consts.svh"

module rectDraw #(
    parameter int  pBitWidth  = `OVL_X_BITS,
    parameter int  pBitHeight = `OVL_Y_BITS,
    parameter type tPayload   = logic [7:0]     // Colour or palette index
)(
    input  logic                  iCLK,
    input  logic                  iRST,         // Sync, active high
    rasterIf.snk                  ras,
    input  logic [pBitWidth-1:0]  iXs,          // Left edge, inclusive
    input  logic [pBitWidth-1:0]  iXe,          // Right edge, inclusive
    input  logic [pBitHeight-1:0] iYs,          // Top edge, inclusive
    input  logic [pBitHeight-1:0] iYe,          // Bottom edge, inclusive
    input  tPayload               iPayload,
    output logic                  oHit,
    output tPayload               oPayload
);

    logic [3:0] rCke;               // Per-edge compare results
    logic       rHit;
    tPayload    rPay [0:1];         // Payload delay line

    //----------------------------------------------------------------------
    // Stage 1
    //----------------------------------------------------------------------
    // Blanking positions never hit
    always_ff @(posedge iCLK)
    begin
        if (iRST)
            rCke <= 4'b0000;
        else
        begin
            rCke[0] <= ras.de && (iXs <= ras.x);
            rCke[1] <= ras.de && (ras.x <= iXe);
            rCke[2] <= ras.de && (iYs <= ras.y);
            rCke[3] <= ras.de && (ras.y <= iYe);
        end
    end

    //----------------------------------------------------------------------
    // Stage 2
    //----------------------------------------------------------------------
    always_ff @(posedge iCLK)
    begin
        if (iRST)
            rHit <= 1'b0;
        else
            rHit <= &rCke;                          // Inside on all sides
    end

    always_ff @(posedge iCLK)
    begin
        rPay[0] <= iPayload;
        rPay[1] <= rPay[0];
    end

    assign oHit     = rHit;
    assign oPayload = rPay[1];

endmodule

// ==== hw/rectOverlay.sv ====
//--------------------------------------------------------------------------
// Rectangle overlay top
// Scanner, fill and marker drawers and the layer mixer. Position to pixel
// latency is 3 cycles
//--------------------------------------------------------------------------
`timescale 1ns/1ns
`include "overlay_consts.svh"

module rectOverlay
(
    input  logic              iCLK,
    input  logic              iRST,         // Sync, active high
    // Fill rectangle, true colour
    input  videoPkg::xPos_t   iFillXs,
    input  videoPkg::xPos_t   iFillXe,
    input  videoPkg::yPos_t   iFillYs,
    input  videoPkg::yPos_t   iFillYe,
    input  pixelPkg::rgb_t    iFillColor,
    // Marker rectangle, palette index
    input  videoPkg::xPos_t   iMarkXs,
    input  videoPkg::xPos_t   iMarkXe,
    input  videoPkg::yPos_t   iMarkYs,
    input  videoPkg::yPos_t   iMarkYe,
    input  pixelPkg::palIdx_t iMarkIdx,
    input  pixelPkg::rgb_t    iBgColor,
    // Palette write port
    input  logic              iPalWe,
    input  pixelPkg::palIdx_t iPalAddr,
    input  pixelPkg::rgb_t    iPalData,
    // Video out
    output pixelPkg::rgb_t    oPixel,
    output logic              oDe,
    output logic              oHsync,
    output logic              oVsync
);

    import pixelPkg::*;

    logic    fillHit, markHit;
    rgb_t    fillColor;             // Fill colour, drawer aligned
    palIdx_t markIdx;               // Marker index, drawer aligned

    rasterIf ras();

    rasterScan rasterScan_i (.iCLK(iCLK), .iRST(iRST), .ras(ras.src));

    //----------------------------------------------------------------------
    // Drawers
    //----------------------------------------------------------------------
    rectDraw #(
        .pBitWidth (`OVL_X_BITS),
        .pBitHeight(`OVL_Y_BITS),
        .tPayload  (rgb_t)
    ) fillDraw (
        .iCLK(iCLK), .iRST(iRST), .ras(ras.snk),
        .iXs(iFillXs), .iXe(iFillXe), .iYs(iFillYs), .iYe(iFillYe),
        .iPayload(iFillColor), .oHit(fillHit), .oPayload(fillColor)
    );

    rectDraw #(
        .pBitWidth (`OVL_X_BITS),
        .pBitHeight(`OVL_Y_BITS),
        .tPayload  (palIdx_t)
    ) markDraw (
        .iCLK(iCLK), .iRST(iRST), .ras(ras.snk),
        .iXs(iMarkXs), .iXe(iMarkXe), .iYs(iMarkYs), .iYe(iMarkYe),
        .iPayload(iMarkIdx), .oHit(markHit), .oPayload(markIdx)
    );

    // Mixer, adds the final output register
    layerMix layerMix_i (
        .iCLK(iCLK), .iRST(iRST), .ras(ras.snk),
        .iFillHit(fillHit), .iFillColor(fillColor),
        .iMarkHit(markHit), .iMarkIdx(markIdx),
        .iBgColor(iBgColor),
        .iPalWe(iPalWe), .iPalAddr(iPalAddr), .iPalData(iPalData),
        .oPixel(oPixel), .oDe(oDe), .oHsync(oHsync), .oVsync(oVsync)
    );

endmodule

// ==== hw/videoPkg.sv ====
//--------------------------------------------------------------------------
// Video timing package
// Raster coordinate types and the bundle of timing flags that travels
// alongside pixel data through the pipeline
//--------------------------------------------------------------------------
`include "overlay_consts.svh"

package videoPkg;

    //----------------------------------------------------------------------
    // Coordinates
    //----------------------------------------------------------------------
    // Horizontal position, covers active and blanking pixels
    typedef logic [`OVL_X_BITS-1:0] xPos_t;

    // Vertical position, covers active and blanking lines
    typedef logic [`OVL_Y_BITS-1:0] yPos_t;

    //----------------------------------------------------------------------
    // Timing flags
    //----------------------------------------------------------------------
    // Delayed as one word to stay aligned with the drawers
    typedef struct packed
    {
        logic de;           // Active area
        logic hsync;        // Line sync, active high
        logic vsync;        // Frame sync, active high
    } syncBits_t;

endpackage
